// ==== source/graphCountPkg.sv ====
package graphCountPkg;

    // 7-dimensional hypercube
    parameter int nodeCount = 128;
    parameter int dimensions = 7;

    // one bit per node, set when the node is in the graph
    typedef logic [nodeCount-1:0] graph_t;

    // at most 64 components fit in the 7-cube
    typedef logic [7:0] count_t;

    // fixed stage latencies in clock cycles
    parameter int maskLatency = 2;
    parameter int singletonLatency = 3;

    // bit i of the result is set when any hypercube neighbor of node i is set in g
    function automatic graph_t neighborsOf(graph_t g);
        graph_t result;
        result = '0;
        for (int node = 0; node < nodeCount; node++) begin
            for (int d = 0; d < dimensions; d++) begin
                // neighbors differ in exactly one index bit
                result[node] = result[node] | g[node ^ (1 << d)];
            end
        end
        return result;
    endfunction

endpackage

// ==== source/delayLine.sv ====
`timescale 1ns/100ps

module delayLine #(
    parameter type payload_t = logic,
    parameter int CYCLES = 1
) (
    input  logic     clk,
    input  payload_t in,
    output payload_t out
);

    // one register per cycle of delay
    payload_t stages [CYCLES];

    always_ff @(posedge clk) begin
        stages[0] <= in;
        for (int i = 1; i < CYCLES; i++) begin
            stages[i] <= stages[i-1];
        end
    end

    assign out = stages[CYCLES-1];

endmodule

// ==== source/graphMasker.sv ====
`timescale 1ns/100ps

module graphMasker (
    input  logic                  clk,
    input  logic                  reset,
    input  graphCountPkg::graph_t top,
    input  graphCountPkg::graph_t bottom,
    output graphCountPkg::graph_t maskedGraph
);

    graphCountPkg::graph_t topReg;
    graphCountPkg::graph_t bottomReg;

    // first stage, local copies of both functions
    always_ff @(posedge clk) begin
        topReg <= top;
        bottomReg <= bottom;
    end

    // second stage, nodes of top that bottom does not cover
    always_ff @(posedge clk) begin
        if (reset) begin
            // empty graph until the first real input has passed through
            maskedGraph <= '0;
        end else begin
            maskedGraph <= topReg & ~bottomReg;
        end
    end

endmodule

// ==== source/singletonCounter.sv ====
`timescale 1ns/100ps

module singletonCounter (
    input  logic                  clk,
    input  graphCountPkg::graph_t graph,
    output graphCountPkg::count_t isolatedCount
);

    // stage one
    graphCountPkg::graph_t graphStage1;
    graphCountPkg::graph_t neighborStage1;

    // stage two
    graphCountPkg::graph_t isolatedMask;

    // stage three input
    graphCountPkg::count_t isolatedSum;

    // any neighbor present, per node
    always_ff @(posedge clk) begin
        graphStage1 <= graph;
        neighborStage1 <= graphCountPkg::neighborsOf(graph);
    end

    // present nodes with no neighbor at all
    always_ff @(posedge clk) begin
        isolatedMask <= graphStage1 & ~neighborStage1;
    end

    // population count of the isolated mask
    always_comb begin
        isolatedSum = '0;
        for (int node = 0; node < graphCountPkg::nodeCount; node++) begin
            isolatedSum = isolatedSum + graphCountPkg::count_t'(isolatedMask[node]);
        end
    end

    always_ff @(posedge clk) begin
        isolatedCount <= isolatedSum;
    end

endmodule

// ==== source/componentExplorer.sv ====
`timescale 1ns/100ps

module componentExplorer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  graphCountPkg::graph_t graph,
    output logic                  done,
    output graphCountPkg::count_t multiCount
);

    // nodes not yet assigned to a finished component
    graphCountPkg::graph_t remaining;
    // component currently being flooded
    graphCountPkg::graph_t flood;

    graphCountPkg::graph_t grownFlood;
    graphCountPkg::graph_t remainingAfter;
    logic                  busy;
    logic                  floodStalled;
    logic                  floodIsMulti;

    // one-hot of the lowest set node, zero for an empty graph
    function automatic graphCountPkg::graph_t lowestNode(graphCountPkg::graph_t g);
        return g & (~g + 1'b1);
    endfunction

    always_comb begin
        // one neighbor wave, limited to unexplored nodes
        grownFlood = flood | (graphCountPkg::neighborsOf(flood) & remaining);
        floodStalled = (grownFlood == flood);
        // more than one bit set
        floodIsMulti = |(flood & (flood - 1'b1));
        remainingAfter = remaining & ~flood;
    end

    // control and count
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            multiCount <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                multiCount <= '0;
                // an empty graph finishes right away
                busy <= (graph != '0);
                done <= (graph == '0);
            end else if (busy && floodStalled) begin
                if (floodIsMulti) begin
                    multiCount <= multiCount + 1'b1;
                end
                if (remainingAfter == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // flood state
    always_ff @(posedge clk) begin
        if (start) begin
            remaining <= graph;
            flood <= lowestNode(graph);
        end else if (busy) begin
            if (floodStalled) begin
                // component complete, drop it and seed the next one
                remaining <= remainingAfter;
                flood <= lowestNode(remainingAfter);
            end else begin
                flood <= grownFlood;
            end
        end
    end

endmodule

// ==== source/countCombiner.sv ====
`timescale 1ns/100ps

module countCombiner #(
    parameter int TAG_WIDTH = 14
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  singletonValid,
    input  logic                  explorerDone,
    input  graphCountPkg::count_t isolatedCount,
    input  graphCountPkg::count_t multiCount,
    input  logic [TAG_WIDTH-1:0]  tagIn,
    output logic                  done,
    output graphCountPkg::count_t componentCount,
    output logic [TAG_WIDTH-1:0]  tagOut
);

    logic                  singletonSeen;
    logic                  explorerSeen;
    graphCountPkg::count_t heldIsolated;
    graphCountPkg::count_t heldMulti;
    logic [TAG_WIDTH-1:0]  heldTag;

    logic                  haveSingleton;
    logic                  haveExplorer;
    graphCountPkg::count_t isolatedNow;
    graphCountPkg::count_t multiNow;
    logic [TAG_WIDTH-1:0]  tagNow;

    // either result may arrive first, or both in the same cycle
    always_comb begin
        haveSingleton = singletonSeen | singletonValid;
        haveExplorer = explorerSeen | explorerDone;
        isolatedNow = singletonSeen ? heldIsolated : isolatedCount;
        multiNow = explorerSeen ? heldMulti : multiCount;
        // the tag travels alongside the singleton result
        tagNow = singletonSeen ? heldTag : tagIn;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            singletonSeen <= 1'b0;
            explorerSeen <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (haveSingleton && haveExplorer) begin
                done <= 1'b1;
                singletonSeen <= 1'b0;
                explorerSeen <= 1'b0;
            end else begin
                if (singletonValid) begin
                    singletonSeen <= 1'b1;
                end
                if (explorerDone) begin
                    explorerSeen <= 1'b1;
                end
            end
        end
    end

    // held values and the final result
    always_ff @(posedge clk) begin
        if (singletonValid) begin
            heldIsolated <= isolatedCount;
            heldTag <= tagIn;
        end
        if (explorerDone) begin
            heldMulti <= multiCount;
        end
        if (haveSingleton && haveExplorer) begin
            componentCount <= isolatedNow + multiNow;
            tagOut <= tagNow;
        end
    end

endmodule

// ==== source/graphCountTop.sv ====
`timescale 1ns/100ps

module graphCountTop #(
    parameter int TAG_WIDTH = 14
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  graphCountPkg::graph_t top,
    input  graphCountPkg::graph_t bottom,
    input  logic [TAG_WIDTH-1:0]  tag,
    output logic                  ready,
    output logic                  done,
    output graphCountPkg::count_t componentCount,
    output logic [TAG_WIDTH-1:0]  tagOut
);

    localparam int singletonDelay = graphCountPkg::maskLatency + graphCountPkg::singletonLatency;

    graphCountPkg::graph_t maskedGraph;
    graphCountPkg::count_t isolatedCount;
    graphCountPkg::count_t multiCount;
    logic                  explorerStart;
    logic                  explorerDone;
    logic                  singletonValid;
    logic [TAG_WIDTH-1:0]  tagAtSingleton;

    graphMasker i_graphMasker (
        .clk         (clk),
        .reset       (reset),
        .top         (top),
        .bottom      (bottom),
        .maskedGraph (maskedGraph)
    );

    // explorer starts once the masked graph is ready
    delayLine #(
        .payload_t (logic),
        .CYCLES    (graphCountPkg::maskLatency)
    ) i_explorerStartDelay (
        .clk (clk),
        .in  (start),
        .out (explorerStart)
    );

    // start and tag aligned with the singleton count
    delayLine #(
        .payload_t (logic),
        .CYCLES    (singletonDelay)
    ) i_singletonValidDelay (
        .clk (clk),
        .in  (start),
        .out (singletonValid)
    );

    delayLine #(
        .payload_t (logic [TAG_WIDTH-1:0]),
        .CYCLES    (singletonDelay)
    ) i_tagDelay (
        .clk (clk),
        .in  (tag),
        .out (tagAtSingleton)
    );

    singletonCounter i_singletonCounter (
        .clk           (clk),
        .graph         (maskedGraph),
        .isolatedCount (isolatedCount)
    );

    componentExplorer i_componentExplorer (
        .clk        (clk),
        .reset      (reset),
        .start      (explorerStart),
        .graph      (maskedGraph),
        .done       (explorerDone),
        .multiCount (multiCount)
    );

    countCombiner #(
        .TAG_WIDTH (TAG_WIDTH)
    ) i_countCombiner (
        .clk            (clk),
        .reset          (reset),
        .singletonValid (singletonValid),
        .explorerDone   (explorerDone),
        .isolatedCount  (isolatedCount),
        .multiCount     (multiCount),
        .tagIn          (tagAtSingleton),
        .done           (done),
        .componentCount (componentCount),
        .tagOut         (tagOut)
    );

    // one graph in flight, busy from start until done
    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= 1'b1;
        end else if (start) begin
            ready <= 1'b0;
        end else if (done) begin
            ready <= 1'b1;
        end
    end

endmodule

// ==== tb/graphCountRef.svh ====
`ifndef GRAPH_COUNT_REF_SVH
`define GRAPH_COUNT_REF_SVH

// the seven hypercube neighbors of one node, as a mask
function automatic graphCountPkg::graph_t refNeighborSet(int node);
    graphCountPkg::graph_t mask;
    mask = '0;
    for (int d = 0; d < graphCountPkg::dimensions; d++) begin
        mask[node ^ (1 << d)] = 1'b1;
    end
    return mask;
endfunction

// present nodes without any present neighbor
function automatic int refIsolatedCount(graphCountPkg::graph_t g);
    int count;
    count = 0;
    for (int node = 0; node < graphCountPkg::nodeCount; node++) begin
        if (g[node] && ((refNeighborSet(node) & g) == '0)) begin
            count++;
        end
    end
    return count;
endfunction

// components with two or more nodes, found by flooding from the lowest node
function automatic int refMultiCount(graphCountPkg::graph_t g);
    graphCountPkg::graph_t left;
    graphCountPkg::graph_t comp;
    graphCountPkg::graph_t grown;
    int count;
    int seedNode;
    bit growing;
    count = 0;
    left = g;
    while (left != '0) begin
        seedNode = 0;
        for (int node = graphCountPkg::nodeCount - 1; node >= 0; node--) begin
            if (left[node]) begin
                seedNode = node;
            end
        end
        comp = '0;
        comp[seedNode] = 1'b1;
        growing = 1'b1;
        while (growing) begin
            grown = comp;
            for (int node = 0; node < graphCountPkg::nodeCount; node++) begin
                if (comp[node]) begin
                    grown = grown | (refNeighborSet(node) & g);
                end
            end
            growing = (grown != comp);
            comp = grown;
        end
        if ($countones(comp) >= 2) begin
            count++;
        end
        left = left & ~comp;
    end
    return count;
endfunction

// every component, isolated nodes included
function automatic int refComponentCount(graphCountPkg::graph_t g);
    return refIsolatedCount(g) + refMultiCount(g);
endfunction

`endif

// ==== tb/graphCountTb.sv ====
`timescale 1ns/100ps

module graphCountTb;

    localparam int tagWidth = 14;
    localparam int fixedEntries = 6;
    localparam int numEntries = 16;
    // worst case explorer time per graph is far below 700 cycles
    localparam int cycleLimit = numEntries * 700 + 20;

    logic                  clk;
    logic                  reset;
    logic                  start;
    graphCountPkg::graph_t top;
    graphCountPkg::graph_t bottom;
    logic [tagWidth-1:0]   tag;
    logic                  ready;
    logic                  done;
    graphCountPkg::count_t componentCount;
    logic [tagWidth-1:0]   tagOut;

    // stimulus table
    graphCountPkg::graph_t tableTop [numEntries];
    graphCountPkg::graph_t tableBottom [numEntries];
    logic [tagWidth-1:0]   tableTag [numEntries];
    int                    tableExpected [numEntries];

    int seed = 32'h1998;
    int doneCount = 0;
    int cycleCount = 0;

    `include "graphCountRef.svh"

    graphCountTop #(
        .TAG_WIDTH (tagWidth)
    ) i_graphCountTop (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .top            (top),
        .bottom         (bottom),
        .tag            (tag),
        .ready          (ready),
        .done           (done),
        .componentCount (componentCount),
        .tagOut         (tagOut)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task stopOnFailure();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task checkValue(input logic [31:0] actual, input logic [31:0] expected, input string message);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s, got %0d, expected %0d",
                     $time, message, actual, expected);
            stopOnFailure();
        end
    endtask

    task drawRandomGraph(output graphCountPkg::graph_t g);
        g = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    task buildTable();
        graphCountPkg::graph_t mix;
        graphCountPkg::graph_t evenNodes;
        graphCountPkg::graph_t extra;
        graphCountPkg::graph_t oneNode;
        evenNodes = '0;
        for (int node = 0; node < graphCountPkg::nodeCount; node++) begin
            evenNodes[node] = ($countones(node) % 2 == 0);
        end
        // edges, a four node chain and lone nodes
        mix = '0;
        mix[0] = 1'b1;
        mix[1] = 1'b1;
        mix[6] = 1'b1;
        mix[40] = 1'b1;
        mix[41] = 1'b1;
        mix[43] = 1'b1;
        mix[47] = 1'b1;
        mix[100] = 1'b1;
        mix[126] = 1'b1;
        mix[127] = 1'b1;
        oneNode = '0;
        oneNode[77] = 1'b1;

        drawRandomGraph(tableTop[0]);
        tableBottom[0] = tableTop[0];
        tableTag[0] = 14'h0001;
        tableTop[1] = '1;
        tableBottom[1] = '0;
        tableTag[1] = 14'h2aaa;
        tableTop[2] = evenNodes;
        tableBottom[2] = '0;
        tableTag[2] = 14'h1234;
        // single node left over by the bottom function
        tableTop[3] = '1;
        tableBottom[3] = ~oneNode;
        tableTag[3] = 14'h3fff;
        tableTop[4] = mix;
        tableBottom[4] = '0;
        tableTag[4] = 14'h0042;
        tableTop[5] = '1;
        tableBottom[5] = ~mix;
        tableTag[5] = 14'h1001;

        for (int i = fixedEntries; i < numEntries; i++) begin
            drawRandomGraph(tableTop[i]);
            drawRandomGraph(tableBottom[i]);
            // every other entry gets a sparser graph
            if (i % 2 == 0) begin
                drawRandomGraph(extra);
                tableBottom[i] = tableBottom[i] | extra;
            end
            tableTag[i] = tagWidth'($random(seed));
        end

        for (int i = 0; i < numEntries; i++) begin
            tableExpected[i] = refComponentCount(tableTop[i] & ~tableBottom[i]);
        end
    endtask

    task runEntry(input int i);
        while (ready !== 1'b1) begin
            @(negedge clk);
        end
        top = tableTop[i];
        bottom = tableBottom[i];
        tag = tableTag[i];
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // top and bottom stay put until the next entry
        while (done !== 1'b1) begin
            checkValue(32'(ready), 0, $sformatf("ready while entry %0d is busy", i));
            @(negedge clk);
        end
        checkValue(32'(componentCount), tableExpected[i],
                   $sformatf("component count of entry %0d", i));
        checkValue(32'(tagOut), 32'(tableTag[i]), $sformatf("tag of entry %0d", i));
        @(negedge clk);
        checkValue(32'(ready), 1, $sformatf("ready after done of entry %0d", i));
        checkValue(32'(done), 0, $sformatf("done width of entry %0d", i));
        checkValue(doneCount, i + 1, $sformatf("done pulses up to entry %0d", i));
        checkValue(32'(componentCount), tableExpected[i],
                   $sformatf("held count of entry %0d", i));
    endtask

    always @(negedge clk) begin
        if (done === 1'b1) begin
            doneCount++;
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout: no finish after %0d clock cycles", cycleCount);
            stopOnFailure();
        end
    end

    initial begin
        start = 1'b0;
        top = '0;
        bottom = '0;
        tag = '0;
        reset = 1'b1;
        buildTable();
        // five rising edges with reset high
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        // idle state before the first start
        checkValue(32'(ready), 1, "ready after reset");
        checkValue(32'(done), 0, "done after reset");
        for (int i = 0; i < numEntries; i++) begin
            runEntry(i);
        end
        repeat (3) @(negedge clk);
        checkValue(doneCount, numEntries, "done pulses in total");
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+tb
source/graphCountPkg.sv
source/delayLine.sv
source/graphMasker.sv
source/singletonCounter.sv
source/componentExplorer.sv
source/countCombiner.sv
source/graphCountTop.sv
tb/graphCountTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the graph count testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module graphCountTb \
    --Mdir obj_dir -o graphCountSim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/graphCountSim)
runStatus=$?
printf '%s\n' "$output"

if [ $runStatus -ne 0 ]; then
    echo "simulation ended with status $runStatus"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
